/* muldiv_cfg_pkg.sv */
/*
  muldiv configuration
  widths, iteration count and order queue depth for the mul/div unit
*/

package muldiv_cfg_pkg;

  // ------------------------------
  // datapath widths
  // ------------------------------

  // operand width of the processor
  localparam int DATA_W = 32;

  // full product, or remainder in the upper half and quotient in the lower
  localparam int RESULT_W = 2 * DATA_W;

  // ------------------------------
  // iteration control
  // ------------------------------

  // one shift step per operand bit
  localparam int ITERS = DATA_W;

  // counter runs from ITERS-1 down to zero
  localparam int CNT_W = $clog2(ITERS);

  // ------------------------------
  // response ordering
  // ------------------------------

  // one multiply and one divide in flight at most
  localparam int ORDER_DEPTH = 2;

endpackage

/* muldiv_msg_pkg.sv */
/*
  muldiv messages
  opcode, request, response, order tag and unit FSM state types
*/

package muldiv_msg_pkg;

  // ------------------------------
  // opcodes
  // ------------------------------

  // signed and unsigned multiply, signed and unsigned divide
  typedef enum logic [1:0] {
    OP_MUL  = 2'd0,
    OP_MULU = 2'd1,
    OP_DIV  = 2'd2,
    OP_DIVU = 2'd3
  } muldiv_op_e;

  // ------------------------------
  // channel payloads
  // ------------------------------

  // request, 66 bits
  typedef struct packed {
    muldiv_op_e                          op;
    logic [muldiv_cfg_pkg::DATA_W-1:0]   a;
    logic [muldiv_cfg_pkg::DATA_W-1:0]   b;
  } muldiv_req_t;

  // response, product or {remainder, quotient}
  typedef struct packed {
    logic [muldiv_cfg_pkg::RESULT_W-1:0] result;
  } muldiv_resp_t;

  // order tag, which unit owns a request
  typedef enum logic {
    UNIT_MUL = 1'b0,
    UNIT_DIV = 1'b1
  } unit_sel_e;

  // shared FSM encoding of the iterative units
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } iter_state_e;

endpackage

/* muldiv_issue.sv */
/*
  muldiv issue stage
  steers each request to the multiplier or divider and tags its order
*/

`timescale 1ns/1ps

module muldiv_issue (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        req_val,
  output logic                        req_rdy,
  input  muldiv_msg_pkg::muldiv_req_t req,
  output logic                        mul_req_val,
  input  logic                        mul_req_rdy,
  output logic                        div_req_val,
  input  logic                        div_req_rdy,
  output muldiv_msg_pkg::muldiv_req_t unit_req,
  output logic                        tag_push,
  output muldiv_msg_pkg::unit_sel_e   tag,
  input  logic                        tag_rdy
);

  import muldiv_msg_pkg::*;

  unit_sel_e sel;
  logic      unit_rdy;

  // ------------------------------
  // opcode decode
  // ------------------------------

  always_comb begin
    case (req.op)
      OP_DIV, OP_DIVU: sel = UNIT_DIV;
      default:         sel = UNIT_MUL;
    endcase
  end

  // ready of the chosen unit only
  assign unit_rdy = (sel == UNIT_DIV) ? div_req_rdy : mul_req_rdy;

  // a request needs a free unit and a free slot in the order queue
  assign req_rdy = unit_rdy && tag_rdy;

  // ------------------------------
  // steering
  // ------------------------------

  // the unit must not take a request whose tag cannot be queued
  assign mul_req_val = req_val && tag_rdy && (sel == UNIT_MUL);
  assign div_req_val = req_val && tag_rdy && (sel == UNIT_DIV);

  // both units see the same payload, only one sees val
  assign unit_req = req;

  // tag goes in on the request transfer edge
  assign tag_push = req_val && req_rdy;
  assign tag      = sel;

  // a waiting request keeps its val and payload, so the steering stays put
  a_req_hold: assert property (@(posedge clk) disable iff (reset)
    (req_val && !req_rdy) |=> (req_val && $stable(req)));

endmodule

/* int_mul_iterative.sv */
/*
  iterative integer multiplier
  shift-and-add on operand magnitudes, sign applied to the 64-bit product
*/

`timescale 1ns/1ps

module int_mul_iterative (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         req_val,
  output logic                         req_rdy,
  input  muldiv_msg_pkg::muldiv_req_t  req,
  output logic                         resp_val,
  input  logic                         resp_rdy,
  output muldiv_msg_pkg::muldiv_resp_t resp
);

  import muldiv_cfg_pkg::*;
  import muldiv_msg_pkg::*;

  iter_state_e         state;
  logic [CNT_W-1:0]    cnt;
  logic [RESULT_W-1:0] a_reg;
  logic [DATA_W-1:0]   b_reg;
  logic [RESULT_W-1:0] acc_reg;
  logic                neg_reg;
  logic                is_signed;
  logic [DATA_W-1:0]   mag_a;
  logic [DATA_W-1:0]   mag_b;
  logic                req_fire;
  logic                resp_fire;

  assign req_fire  = req_val && req_rdy;
  assign resp_fire = resp_val && resp_rdy;

  // ------------------------------
  // operand magnitudes
  // ------------------------------

  // unsigned opcode passes the raw operands
  assign is_signed = (req.op == OP_MUL);
  assign mag_a = (is_signed && req.a[DATA_W-1]) ? (~req.a + 1'b1) : req.a;
  assign mag_b = (is_signed && req.b[DATA_W-1]) ? (~req.b + 1'b1) : req.b;

  // ------------------------------
  // control FSM
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req_fire) begin
            state <= CALC;
            // ITERS steps, last one at count zero
            cnt   <= CNT_W'(ITERS - 1);
          end
        end
        CALC: begin
          cnt <= cnt - 1'b1;
          if (cnt == '0) begin
            state <= DONE;
          end
        end
        DONE: begin
          // hold the product until the merger takes it
          if (resp_fire) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ------------------------------
  // datapath
  // ------------------------------

  always_ff @(posedge clk) begin
    if (req_fire) begin
      a_reg   <= {{(RESULT_W - DATA_W){1'b0}}, mag_a};
      b_reg   <= mag_b;
      acc_reg <= '0;
      // product is negative when exactly one signed operand is negative
      neg_reg <= is_signed && (req.a[DATA_W-1] ^ req.b[DATA_W-1]);
    end else if (state == CALC) begin
      // add the shifted multiplicand for each set multiplier bit
      if (b_reg[0]) begin
        acc_reg <= acc_reg + a_reg;
      end
      a_reg <= a_reg << 1;
      b_reg <= b_reg >> 1;
    end
  end

  // ------------------------------
  // response
  // ------------------------------

  assign req_rdy     = (state == IDLE);
  assign resp_val    = (state == DONE);
  // two's complement of the magnitude product when the sign is set
  assign resp.result = neg_reg ? (~acc_reg + 1'b1) : acc_reg;

  // a waiting response does not change under the merger
  a_resp_stable: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp)));

  // every multiplier bit consumed by the time the product is offered
  a_bits_used: assert property (@(posedge clk) disable iff (reset)
    resp_val |-> (b_reg == '0));

endmodule

/* int_div_iterative.sv */
/*
  iterative integer divider
  restoring shift-and-subtract, result is {remainder, quotient}
*/

`timescale 1ns/1ps

module int_div_iterative (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         req_val,
  output logic                         req_rdy,
  input  muldiv_msg_pkg::muldiv_req_t  req,
  output logic                         resp_val,
  input  logic                         resp_rdy,
  output muldiv_msg_pkg::muldiv_resp_t resp
);

  import muldiv_cfg_pkg::*;
  import muldiv_msg_pkg::*;

  iter_state_e       state;
  logic [CNT_W-1:0]  cnt;
  logic [DATA_W-1:0] rem_reg;
  logic [DATA_W-1:0] quo_reg;
  logic [DATA_W-1:0] dvsr_reg;
  logic              qneg_reg;
  logic              rneg_reg;
  logic              is_signed;
  logic [DATA_W-1:0] mag_a;
  logic [DATA_W-1:0] mag_b;
  logic [DATA_W:0]   rem_shift;
  logic [DATA_W+1:0] trial;
  logic              keep;
  logic [DATA_W-1:0] quo_out;
  logic [DATA_W-1:0] rem_out;
  logic              req_fire;
  logic              resp_fire;

  assign req_fire  = req_val && req_rdy;
  assign resp_fire = resp_val && resp_rdy;

  // ------------------------------
  // operand magnitudes
  // ------------------------------

  assign is_signed = (req.op == OP_DIV);
  assign mag_a = (is_signed && req.a[DATA_W-1]) ? (~req.a + 1'b1) : req.a;
  assign mag_b = (is_signed && req.b[DATA_W-1]) ? (~req.b + 1'b1) : req.b;

  // ------------------------------
  // control FSM
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req_fire) begin
            state <= CALC;
            cnt   <= CNT_W'(ITERS - 1);
          end
        end
        CALC: begin
          cnt <= cnt - 1'b1;
          if (cnt == '0) begin
            state <= DONE;
          end
        end
        DONE: begin
          if (resp_fire) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ------------------------------
  // restoring step
  // ------------------------------

  // next dividend bit enters the partial remainder
  assign rem_shift = {rem_reg, quo_reg[DATA_W-1]};
  // extra top bit carries the borrow
  assign trial = {1'b0, rem_shift} - {2'b00, dvsr_reg};
  assign keep  = !trial[DATA_W+1];

  always_ff @(posedge clk) begin
    if (req_fire) begin
      rem_reg  <= '0;
      quo_reg  <= mag_a;
      dvsr_reg <= mag_b;
      // zero divisor keeps the all-ones quotient unsigned
      qneg_reg <= is_signed && (req.a[DATA_W-1] ^ req.b[DATA_W-1]) && (req.b != '0);
      // remainder follows the dividend
      rneg_reg <= is_signed && req.a[DATA_W-1];
    end else if (state == CALC) begin
      // a kept difference is below the divisor and fits DATA_W bits
      rem_reg <= keep ? trial[DATA_W-1:0] : rem_shift[DATA_W-1:0];
      quo_reg <= {quo_reg[DATA_W-2:0], keep};
    end
  end

  // ------------------------------
  // sign fix and response
  // ------------------------------

  // most negative / -1 gives magnitude 2^31 with a positive sign,
  // which is the dividend bit pattern again
  assign quo_out = qneg_reg ? (~quo_reg + 1'b1) : quo_reg;
  assign rem_out = rneg_reg ? (~rem_reg + 1'b1) : rem_reg;

  assign req_rdy     = (state == IDLE);
  assign resp_val    = (state == DONE);
  assign resp.result = {rem_out, quo_out};

  // partial remainder ends below a nonzero divisor
  a_rem_below_dvsr: assert property (@(posedge clk) disable iff (reset)
    resp_val |-> ((dvsr_reg == '0) || (rem_reg < dvsr_reg)));

endmodule

/* muldiv_resp_merge.sv */
/*
  muldiv response merger
  order tag queue, passes unit responses out in request order
*/

`timescale 1ns/1ps

module muldiv_resp_merge (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         tag_push,
  input  muldiv_msg_pkg::unit_sel_e    tag,
  output logic                         tag_rdy,
  input  logic                         mul_resp_val,
  output logic                         mul_resp_rdy,
  input  muldiv_msg_pkg::muldiv_resp_t mul_resp,
  input  logic                         div_resp_val,
  output logic                         div_resp_rdy,
  input  muldiv_msg_pkg::muldiv_resp_t div_resp,
  output logic                         resp_val,
  input  logic                         resp_rdy,
  output muldiv_msg_pkg::muldiv_resp_t resp
);

  import muldiv_cfg_pkg::*;
  import muldiv_msg_pkg::*;

  unit_sel_e                          tag_q [ORDER_DEPTH];
  logic [$clog2(ORDER_DEPTH)-1:0]     wr_ptr;
  logic [$clog2(ORDER_DEPTH)-1:0]     rd_ptr;
  logic [$clog2(ORDER_DEPTH+1)-1:0]   count;
  unit_sel_e                          head;
  logic                               empty;
  logic                               pop;

  // ------------------------------
  // tag queue
  // ------------------------------

  assign empty   = (count == '0);
  assign tag_rdy = (count != ORDER_DEPTH);
  assign head    = tag_q[rd_ptr];
  assign pop     = resp_val && resp_rdy;

  // tag storage, no reset
  always_ff @(posedge clk) begin
    if (tag_push) begin
      tag_q[wr_ptr] <= tag;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (tag_push) begin
        wr_ptr <= (wr_ptr == ORDER_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ORDER_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      // push and pop together leave the count alone
      if (tag_push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !tag_push) begin
        count <= count - 1'b1;
      end
    end
  end

  // ------------------------------
  // head selects the unit
  // ------------------------------

  assign resp_val = !empty && ((head == UNIT_DIV) ? div_resp_val : mul_resp_val);
  assign resp     = (head == UNIT_DIV) ? div_resp : mul_resp;

  // a unit out of turn keeps waiting in DONE
  assign mul_resp_rdy = !empty && (head == UNIT_MUL) && resp_rdy;
  assign div_resp_rdy = !empty && (head == UNIT_DIV) && resp_rdy;

  a_no_push_full: assert property (@(posedge clk) disable iff (reset)
    tag_push |-> (count != ORDER_DEPTH));

  // a finished unit always has its tag waiting in the queue
  a_tag_for_resp: assert property (@(posedge clk) disable iff (reset)
    (mul_resp_val || div_resp_val) |-> !empty);

endmodule

/* muldiv_unit.sv */
/*
  muldiv unit top
  issue stage, multiplier and divider side by side, ordered response merger
*/

`timescale 1ns/1ps

module muldiv_unit (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         req_val,
  output logic                         req_rdy,
  input  muldiv_msg_pkg::muldiv_req_t  req,
  output logic                         resp_val,
  input  logic                         resp_rdy,
  output muldiv_msg_pkg::muldiv_resp_t resp
);

  import muldiv_msg_pkg::*;

  // issue to units
  logic         mul_req_val;
  logic         mul_req_rdy;
  logic         div_req_val;
  logic         div_req_rdy;
  muldiv_req_t  unit_req;

  // issue to merger
  logic         tag_push;
  unit_sel_e    tag;
  logic         tag_rdy;

  // units to merger
  logic         mul_resp_val;
  logic         mul_resp_rdy;
  muldiv_resp_t mul_resp;
  logic         div_resp_val;
  logic         div_resp_rdy;
  muldiv_resp_t div_resp;

  muldiv_issue issue (
    .clk(clk), .reset(reset),
    .req_val(req_val), .req_rdy(req_rdy), .req(req),
    .mul_req_val(mul_req_val), .mul_req_rdy(mul_req_rdy),
    .div_req_val(div_req_val), .div_req_rdy(div_req_rdy),
    .unit_req(unit_req),
    .tag_push(tag_push), .tag(tag), .tag_rdy(tag_rdy)
  );

  int_mul_iterative mul (
    .clk(clk), .reset(reset),
    .req_val(mul_req_val), .req_rdy(mul_req_rdy), .req(unit_req),
    .resp_val(mul_resp_val), .resp_rdy(mul_resp_rdy), .resp(mul_resp)
  );

  int_div_iterative div (
    .clk(clk), .reset(reset),
    .req_val(div_req_val), .req_rdy(div_req_rdy), .req(unit_req),
    .resp_val(div_resp_val), .resp_rdy(div_resp_rdy), .resp(div_resp)
  );

  muldiv_resp_merge merge (
    .clk(clk), .reset(reset),
    .tag_push(tag_push), .tag(tag), .tag_rdy(tag_rdy),
    .mul_resp_val(mul_resp_val), .mul_resp_rdy(mul_resp_rdy), .mul_resp(mul_resp),
    .div_resp_val(div_resp_val), .div_resp_rdy(div_resp_rdy), .div_resp(div_resp),
    .resp_val(resp_val), .resp_rdy(resp_rdy), .resp(resp)
  );

endmodule

/* muldiv_tb.sv */
/*
  muldiv unit testbench
  corner, random and back-pressured requests checked against a reference model
*/

`timescale 1ns/1ps

module muldiv_tb;

  import muldiv_cfg_pkg::*;
  import muldiv_msg_pkg::*;

  localparam int SEED           = 33667;
  localparam int EXP_DEPTH      = 1024;
  localparam int BP_LEN         = 1024;
  localparam int LONE_LAT       = 33;
  localparam int ACCEPT_TIMEOUT = 1000;
  localparam int DRAIN_TIMEOUT  = 4000;
  localparam int N_RANDOM       = 200;
  localparam int N_PAIRS        = 60;

  logic         clk;
  logic         reset;
  logic         req_val;
  logic         req_rdy;
  muldiv_req_t  req;
  logic         resp_val;
  logic         resp_rdy;
  muldiv_resp_t resp;

  // expected results, written at request transfer, read at response transfer
  logic [RESULT_W-1:0] exp_mem [EXP_DEPTH];
  logic [RESULT_W-1:0] exp_head;
  // resp_rdy pattern for back-pressure phases
  logic                bp_pat [BP_LEN];
  logic                bp_on;
  logic                lone_mode;
  logic [DATA_W-1:0]   corner [4];
  int                  req_count    = 0;
  int                  resp_count   = 0;
  int                  sent_count   = 0;
  int                  cycle        = 0;
  int                  accept_cycle = 0;

  muldiv_unit uut (
    .clk(clk), .reset(reset),
    .req_val(req_val), .req_rdy(req_rdy), .req(req),
    .resp_val(resp_val), .resp_rdy(resp_rdy), .resp(resp)
  );

  // ------------------------------
  // reference model
  // ------------------------------

  // both operands widened to 64 bits, low half of the product is exact
  function automatic logic [RESULT_W-1:0] ref_mul(input muldiv_op_e op,
      input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
    logic [RESULT_W-1:0] wa;
    logic [RESULT_W-1:0] wb;
    if (op == OP_MUL) begin
      wa = {{DATA_W{a[DATA_W-1]}}, a};
      wb = {{DATA_W{b[DATA_W-1]}}, b};
    end else begin
      wa = {{DATA_W{1'b0}}, a};
      wb = {{DATA_W{1'b0}}, b};
    end
    return wa * wb;
  endfunction

  // {remainder, quotient}, division truncates toward zero
  function automatic logic [RESULT_W-1:0] ref_div(input muldiv_op_e op,
      input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
    logic signed [DATA_W-1:0] sa;
    logic signed [DATA_W-1:0] sb;
    logic [DATA_W-1:0]        q;
    logic [DATA_W-1:0]        r;
    sa = a;
    sb = b;
    if (b == '0) begin
      // zero divisor
      q = '1;
      r = a;
    end else if (op == OP_DIVU) begin
      q = a / b;
      r = a % b;
    end else if (a == {1'b1, {(DATA_W-1){1'b0}}} && b == '1) begin
      // signed overflow
      q = a;
      r = '0;
    end else begin
      // remainder takes the sign of the dividend
      q = sa / sb;
      r = sa % sb;
    end
    return {r, q};
  endfunction

  function automatic logic [RESULT_W-1:0] expected_result(input muldiv_req_t r);
    if (r.op == OP_MUL || r.op == OP_MULU) begin
      return ref_mul(r.op, r.a, r.b);
    end
    return ref_div(r.op, r.a, r.b);
  endfunction

  function automatic logic [DATA_W-1:0] rand_operand();
    logic [DATA_W-1:0] v;
    case ($urandom_range(7, 0))
      0: v = '0;
      1: v = DATA_W'(1);
      2: v = '1;
      3: v = {1'b1, {(DATA_W-1){1'b0}}};
      // small values, long quotients
      4: v = $urandom >> $urandom_range(31, 1);
      default: v = $urandom;
    endcase
    return v;
  endfunction

  function automatic muldiv_op_e rand_op();
    return muldiv_op_e'(2'($urandom_range(3, 0)));
  endfunction

  // ------------------------------
  // failure and handshake tasks
  // ------------------------------

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Errors found");
    $fatal(1);
  endtask

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic send_req(input muldiv_op_e op, input logic [DATA_W-1:0] a,
      input logic [DATA_W-1:0] b);
    int start;
    int waited;
    start   = req_count;
    waited  = 0;
    req_val = 1'b1;
    req.op  = op;
    req.a   = a;
    req.b   = b;
    sent_count++;
    while (req_count == start) begin
      @(negedge clk);
      waited++;
      if (waited > ACCEPT_TIMEOUT) begin
        stop_on_error("timeout waiting for a request to be accepted");
      end
    end
    req_val = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (resp_count != req_count) begin
      @(negedge clk);
      waited++;
      if (waited > DRAIN_TIMEOUT) begin
        stop_on_error("timeout waiting for outstanding responses");
      end
    end
  endtask

  task automatic run_lone(input muldiv_op_e op, input logic [DATA_W-1:0] a,
      input logic [DATA_W-1:0] b);
    send_req(op, a, b);
    wait_drain();
  endtask

  // ------------------------------
  // clock, monitors and checks
  // ------------------------------

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(negedge clk) begin
    resp_rdy = bp_on ? bp_pat[cycle % BP_LEN] : 1'b1;
  end

  assign exp_head = exp_mem[resp_count % EXP_DEPTH];

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (!reset && req_val && req_rdy) begin
      exp_mem[req_count % EXP_DEPTH] <= expected_result(req);
      req_count    <= req_count + 1;
      accept_cycle <= cycle;
    end
    if (!reset && resp_val && resp_rdy) begin
      resp_count <= resp_count + 1;
    end
  end

  a_reset_idle: assert property (@(posedge clk) $fell(reset) |-> (req_rdy && !resp_val))
    else stop_on_error($sformatf("ERROR at %0t: handshake not idle after reset", $time));

  a_resp_owed: assert property (@(posedge clk) disable iff (reset)
    (resp_val && resp_rdy) |-> (resp_count < req_count))
    else stop_on_error($sformatf("ERROR at %0t: response with no open request", $time));

  // in order and exact, head of the expected queue
  a_resp_value: assert property (@(posedge clk) disable iff (reset)
    (resp_val && resp_rdy) |-> (resp.result == exp_head))
    else stop_on_error($sformatf("ERROR at %0t: response %0d is %h, expected %h",
      $time, $sampled(resp_count), $sampled(resp.result), $sampled(exp_head)));

  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp)))
    else stop_on_error($sformatf("ERROR at %0t: waiting response changed", $time));

  // lone request, resp_rdy high, transfer on the 33rd edge after acceptance
  a_lone_latency: assert property (@(posedge clk) disable iff (reset)
    (lone_mode && resp_val) |-> (cycle == accept_cycle + LONE_LAT))
    else stop_on_error($sformatf("ERROR at %0t: lone response after %0d cycles",
      $time, $sampled(cycle) - $sampled(accept_cycle)));

  // ------------------------------
  // stimulus
  // ------------------------------

  initial begin
    reset     = 1'b1;
    req_val   = 1'b0;
    req       = '0;
    resp_rdy  = 1'b1;
    bp_on     = 1'b0;
    lone_mode = 1'b0;
    void'($urandom(SEED));
    for (int i = 0; i < BP_LEN; i++) begin
      bp_pat[i] = ($urandom_range(3, 0) != 0);
    end
    corner[0] = '0;
    corner[1] = DATA_W'(1);
    corner[2] = '1;
    corner[3] = {1'b1, {(DATA_W-1){1'b0}}};

    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // one request at a time, latency measured
    lone_mode = 1'b1;
    run_lone(OP_MUL, $urandom, $urandom);
    run_lone(OP_MULU, $urandom, $urandom);
    run_lone(OP_DIV, $urandom, rand_operand());
    run_lone(OP_DIVU, $urandom, rand_operand());
    lone_mode = 1'b0;

    // every opcode over all corner operand pairs
    for (int o = 0; o < 4; o++) begin
      for (int i = 0; i < 4; i++) begin
        for (int j = 0; j < 4; j++) begin
          send_req(muldiv_op_e'(2'(o)), corner[i], corner[j]);
        end
      end
    end
    send_req(OP_DIV, $urandom, '0);
    send_req(OP_DIVU, $urandom, '0);
    send_req(OP_DIV, corner[3], corner[2]);

    // random mix under back-pressure
    bp_on = 1'b1;
    repeat (N_RANDOM) begin
      send_req(rand_op(), rand_operand(), rand_operand());
    end

    // divide then multiply at once, both units busy together
    repeat (N_PAIRS) begin
      send_req(($urandom_range(1, 0) != 0) ? OP_DIV : OP_DIVU, $urandom, rand_operand());
      send_req(($urandom_range(1, 0) != 0) ? OP_MUL : OP_MULU, rand_operand(), $urandom);
    end

    bp_on = 1'b0;
    wait_drain();

    // nothing may still be offered once every request is answered
    if (resp_count != req_count || req_count != sent_count || resp_val) begin
      stop_on_error($sformatf("ERROR at %0t: %0d sent, %0d accepted, %0d responses, resp_val %b",
        $time, sent_count, req_count, resp_count, resp_val));
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

/* flist.f */
muldiv_cfg_pkg.sv
muldiv_msg_pkg.sv
muldiv_issue.sv
int_mul_iterative.sv
int_div_iterative.sv
muldiv_resp_merge.sv
muldiv_unit.sv
muldiv_tb.sv

/* Makefile */
# Verilator build and run of the muldiv unit testbench

VERILATOR ?= verilator
TOP       ?= muldiv_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)

check: run
	@grep -q "No errors" $(LOG) && echo "PASS" || { echo "FAIL"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
